// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_pd
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= No errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: instr_decoder.sv
// Instruction register with SI1 invalidation, and the opcode group and field
// decoder feeding the legality unit and the STATUS register.
module instr_decoder
	import pd_pkg::*;
(
	input  logic       clk_sys,
	input  logic       rst_n,
	input  logic       ir_load,
	input  word_t      ir_in,
	input  logic       si1,
	output word_t      ir,
	output pd_decode_t dec
);

	// Opcode positions within a major group, from IR bits 2..5
	localparam logic [3:0] OP_OU  = 4'd13;	// Group 01
	localparam logic [3:0] OP_IN  = 4'd14;
	localparam logic [3:0] OP_JS  = 4'd8;	// Group 11
	localparam logic [3:0] OP_KA2 = 4'd9;
	localparam logic [3:0] OP_C   = 4'd10;
	localparam logic [3:0] OP_S   = 4'd11;
	localparam logic [3:0] OP_J   = 4'd12;
	localparam logic [3:0] OP_BN  = 4'd15;

	word_t      ir_q;
	logic [3:0] op;
	logic       g01;
	logic       g11;
	logic       s_grp;
	field3_t    a_fld;
	field3_t    b_fld;

	// SI1 pulls bits 0 and 1 low, pushing the word into group 00
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			ir_q <= '0;
		end else if (ir_load) begin
			ir_q[0:1]  <= si1 ? 2'b00 : ir_in[0:1];
			ir_q[2:15] <= ir_in[2:15];
		end else if (si1) begin
			ir_q[0:1] <= 2'b00;	// Held cleared
		end
	end

	assign ir    = ir_q;
	assign op    = ir_q[2:5];
	assign a_fld = ir_q[7:9];	// Bit 7 is the MSB
	assign b_fld = ir_q[10:12];
	assign g01   = (ir_q[0:1] == 2'b01);
	assign g11   = (ir_q[0:1] == 2'b11);
	assign s_grp = g11 && (op == OP_S);

	// Major groups
	assign dec.grp_01 = g01;
	assign dec.grp_10 = (ir_q[0:1] == 2'b10);
	assign dec.grp_11 = g11;

	// Group 01 I/O
	assign dec.in   = g01 && (op == OP_IN);
	assign dec.ou   = g01 && (op == OP_OU);
	assign dec.inou = g01 && (op == OP_IN || op == OP_OU);

	// Group 11 (KA1 and friends)
	assign dec.s_grp  = s_grp;
	assign dec.c_grp  = g11 && (op == OP_C);
	assign dec.bn_grp = g11 && (op == OP_BN);
	assign dec.j_grp  = g11 && (op == OP_J);
	assign dec.js_grp = g11 && (op == OP_JS);
	assign dec.ka2    = g11 && (op == OP_KA2);

	// S-group by A field
	assign dec.hlt = s_grp && (a_fld == 3'd0);
	assign dec.mcl = s_grp && (a_fld == 3'd1);
	assign dec.sin = s_grp && (a_fld == 3'd2);	// SIU, SIL, SIT, CIT
	assign dec.gi  = s_grp && (a_fld == 3'd3);
	assign dec.lip = s_grp && (a_fld == 3'd4);

	// Fields
	assign dec.a_fld = a_fld;
	assign dec.b_fld = b_fld;
	assign dec.c_fld = ir_q[13:15];
	assign dec.b0    = (b_fld == 3'd0);	// No B-modification
	assign dec.c0    = |ir_q[13:15];	// Argument in register, not next word
	assign dec.b_1   = (b_fld == 3'd1);

	a_grp_onehot: assert property (@(posedge clk_sys) disable iff (!rst_n)
		$onehot0({dec.grp_01, dec.grp_10, dec.grp_11}));

endmodule

// File: legality_check.sv
// Flags the decoded instruction as illegal (xi) or ineffective (nef) from the
// mode flags, the R0 condition flags and the pre-modification limit.
module legality_check
	import pd_pkg::*;
#(
	parameter bit INOU_USER_ILLEGAL = 1'b1	// IN and OU trap in user mode
) (
	input  pd_decode_t dec,
	input  pd_ctrl_t   ctrl,
	input  r0_flags_t  r0,
	output logic       xi,
	output logic       nef
);

	// R0 flag positions
	localparam int F_Z = 0;
	localparam int F_M = 1;
	localparam int F_V = 2;
	localparam int F_C = 3;
	localparam int F_L = 4;
	localparam int F_E = 5;
	localparam int F_G = 6;
	localparam int F_Y = 7;
	localparam int F_X = 8;

	logic no_grp;
	logic a_hi;
	logic user_trap;
	logic form_trap;
	logic jmp_skip;

	assign no_grp = !(dec.grp_01 || dec.grp_10 || dec.grp_11);	// Group 00
	assign a_hi   = (dec.a_fld >= 3'd5);	// A field 5..7

	// Privileged in user mode
	assign user_trap = ctrl.q && (dec.s_grp
		|| (INOU_USER_ILLEGAL && dec.inou)
		|| (dec.bn_grp && a_hi));

	// Reserved encodings and the MD chain limit
	assign form_trap = (dec.s_grp && a_hi)
		|| (dec.c_grp && (dec.b_fld[2] || (dec.b_fld[1] && dec.b_fld[0])))
		|| (dec.bn_grp && (dec.a_fld == 3'd5) && ctrl.mc3)
		|| (dec.c_grp && dec.b_1 && (dec.c_fld[2] || dec.c_fld[1]));

	// Conditional jumps not taken
	always_comb begin
		jmp_skip = 1'b0;
		if (dec.j_grp) begin
			case (dec.a_fld)
				3'd1:    jmp_skip = !r0[F_L];	// JL
				3'd2:    jmp_skip = !r0[F_E];	// JE
				3'd3:    jmp_skip = !r0[F_G];	// JG
				3'd4:    jmp_skip = !r0[F_Z];	// JZ
				3'd5:    jmp_skip = !r0[F_M];	// JM
				3'd6:    jmp_skip = r0[F_E];	// JN
				default: jmp_skip = 1'b0;
			endcase
		end else if (dec.js_grp) begin
			case (dec.a_fld)
				3'd1:    jmp_skip = !r0[F_L];	// JLS
				3'd2:    jmp_skip = !r0[F_E];	// JES
				3'd3:    jmp_skip = !r0[F_G];	// JGS
				3'd4:    jmp_skip = !r0[F_V];	// JVS
				3'd5:    jmp_skip = !r0[F_X];	// JXS
				3'd6:    jmp_skip = !r0[F_Y];	// JYS
				3'd7:    jmp_skip = !r0[F_C];	// JCS
				default: jmp_skip = 1'b0;
			endcase
		end
	end

	assign xi  = no_grp || user_trap || form_trap;
	assign nef = no_grp || user_trap || form_trap || ctrl.p || jmp_skip;

	// An illegal instruction is never executed
	always_comb begin
		a_xi_nef: assert (!xi || nef);
	end

endmodule

// File: pd_pkg.sv
// Shared types and constants of the P-D instruction decode stage.
// Imported by the register block, the decoder, the legality unit and the top.
package pd_pkg;

	// Machine word, bit 0 is the MSB as in the original numbering
	typedef logic [0:15] word_t;
	// R0 flags: 0 Z, 1 M, 2 V, 3 C, 4 L, 5 E, 6 G, 7 Y, 8 X
	typedef logic [8:0]  r0_flags_t;
	typedef logic [2:0]  field3_t;	// A, B or C field, numeric value

	// AXI4-Lite widths
	typedef logic [3:0]  addr_t;
	typedef logic [31:0] data_t;
	typedef logic [1:0]  resp_t;

	localparam resp_t RESP_OKAY   = 2'b00;
	localparam resp_t RESP_SLVERR = 2'b10;

	typedef struct packed {
		logic q;		// User mode
		logic si1;		// Invalidate IR
		logic p;		// Skip flag
		logic mc3;		// Three pre-modifications done
	} pd_ctrl_t;

	typedef struct packed {
		logic    grp_01;	// Opcodes 020..037
		logic    grp_10;	// Opcodes 040..057
		logic    grp_11;	// Opcodes 060..077
		logic    in;
		logic    ou;
		logic    inou;		// IN or OU
		logic    s_grp;
		logic    c_grp;
		logic    bn_grp;
		logic    j_grp;
		logic    js_grp;
		logic    ka2;
		logic    hlt;		// S-group sub-decode
		logic    mcl;
		logic    sin;
		logic    gi;
		logic    lip;
		field3_t a_fld;
		field3_t b_fld;
		field3_t c_fld;
		logic    b0;		// B field zero
		logic    c0;		// C field nonzero
		logic    b_1;		// B field equal to 1
	} pd_decode_t;

	typedef enum logic [1:0] {
		AXIL_IDLE,
		AXIL_WRESP,
		AXIL_RDATA
	} axil_phase_e;

	// Register map
	localparam addr_t REG_IR     = 4'h0;
	localparam addr_t REG_CTRL   = 4'h4;
	localparam addr_t REG_R0     = 4'h8;
	localparam addr_t REG_STATUS = 4'hc;

	// STATUS bit positions
	localparam int ST_XI    = 0;
	localparam int ST_NEF   = 1;
	localparam int ST_C0    = 2;
	localparam int ST_B0    = 3;
	localparam int ST_INOU  = 4;
	localparam int ST_HLT   = 5;
	localparam int ST_SGRP  = 6;
	localparam int ST_A_LSB = 7;	// A field in 9..7

endpackage

// File: pd_regs.sv
// AXI4-Lite slave of the decode stage: CTRL and R0 storage, IR load strobe,
// and the STATUS word built from the decoder and legality results.
module pd_regs
	import pd_pkg::*;
(
	input  logic       clk_sys,
	input  logic       rst_n,
	input  addr_t      awaddr,
	input  logic       awvalid,
	output logic       awready,
	input  data_t      wdata,
	input  logic [3:0] wstrb,
	input  logic       wvalid,
	output logic       wready,
	output logic       bvalid,
	output resp_t      bresp,
	input  logic       bready,
	input  addr_t      araddr,
	input  logic       arvalid,
	output logic       arready,
	output logic       rvalid,
	output data_t      rdata,
	output resp_t      rresp,
	input  logic       rready,
	input  word_t      ir,
	input  pd_decode_t dec,
	input  logic       xi,
	input  logic       nef,
	output logic       ir_load,
	output word_t      ir_in,
	output pd_ctrl_t   ctrl,
	output r0_flags_t  r0
);

	axil_phase_e phase;
	logic        wr_acc;
	logic        rd_acc;
	logic        wr_err;
	logic        rd_err;
	data_t       status;
	data_t       rd_mux;

	assign wr_acc  = (phase == AXIL_IDLE) && awvalid && wvalid;	// Both channels together
	assign rd_acc  = (phase == AXIL_IDLE) && arvalid && !(awvalid && wvalid);	// Write wins
	assign awready = wr_acc;
	assign wready  = wr_acc;
	assign arready = rd_acc;
	assign bvalid  = (phase == AXIL_WRESP);
	assign rvalid  = (phase == AXIL_RDATA);

	// Only IR, CTRL and R0 are writable
	assign wr_err = !(awaddr inside {REG_IR, REG_CTRL, REG_R0});
	assign rd_err = !(araddr inside {REG_IR, REG_CTRL, REG_R0, REG_STATUS});

	assign ir_load = wr_acc && (awaddr == REG_IR);	// Single cycle, IR takes it on this edge
	assign ir_in   = wdata[15:0];

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			phase <= AXIL_IDLE;
		end else begin
			case (phase)
				AXIL_IDLE:  if (wr_acc) phase <= AXIL_WRESP;
				            else if (rd_acc) phase <= AXIL_RDATA;
				AXIL_WRESP: if (bready) phase <= AXIL_IDLE;
				AXIL_RDATA: if (rready) phase <= AXIL_IDLE;
				default:    phase <= AXIL_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			ctrl <= '0;
			r0   <= '0;
		end else if (wr_acc) begin
			if (awaddr == REG_CTRL) begin
				ctrl.q   <= wdata[0];
				ctrl.si1 <= wdata[1];
				ctrl.p   <= wdata[2];
				ctrl.mc3 <= wdata[3];
			end
			if (awaddr == REG_R0)
				r0 <= wdata[8:0];	// Z in bit 0 up to X in bit 8
		end
	end

	always_comb begin
		status                   = '0;
		status[ST_XI]            = xi;
		status[ST_NEF]           = nef;
		status[ST_C0]            = dec.c0;
		status[ST_B0]            = dec.b0;
		status[ST_INOU]          = dec.inou;
		status[ST_HLT]           = dec.hlt;
		status[ST_SGRP]          = dec.s_grp;
		status[ST_A_LSB +: 3]    = dec.a_fld;
	end

	always_comb begin
		case (araddr)
			REG_IR:     rd_mux = {16'h0, ir};
			REG_CTRL:   rd_mux = {28'h0, ctrl.mc3, ctrl.p, ctrl.si1, ctrl.q};
			REG_R0:     rd_mux = {23'h0, r0};
			REG_STATUS: rd_mux = status;
			default:    rd_mux = '0;	// Unmapped reads as zero
		endcase
	end

	// Response payload, captured at acceptance
	always_ff @(posedge clk_sys) begin
		if (wr_acc)
			bresp <= wr_err ? RESP_SLVERR : RESP_OKAY;
		if (rd_acc) begin
			rdata <= rd_mux;
			rresp <= rd_err ? RESP_SLVERR : RESP_OKAY;
		end
	end

	// Responses must wait for the host
	a_bvalid_hold: assert property (@(posedge clk_sys) disable iff (!rst_n)
		bvalid && !bready |=> bvalid);
	a_rvalid_hold: assert property (@(posedge clk_sys) disable iff (!rst_n)
		rvalid && !rready |=> rvalid);
	a_ir_load_pulse: assert property (@(posedge clk_sys) disable iff (!rst_n)
		ir_load |=> !ir_load);
	// Strobes are ignored but must not float on an accepted write
	a_wstrb_known: assert property (@(posedge clk_sys) disable iff (!rst_n)
		wr_acc |-> !$isunknown(wstrb));

endmodule

// File: pd_top.sv
// Top of the P-D decode stage: AXI4-Lite register block, IR and decoder,
// legality unit. The illegal and ineffective flags are also brought out.
module pd_top
	import pd_pkg::*;
#(
	parameter bit INOU_USER_ILLEGAL = 1'b1
) (
	input  logic       clk_sys,
	input  logic       rst_n,
	input  addr_t      awaddr,
	input  logic       awvalid,
	output logic       awready,
	input  data_t      wdata,
	input  logic [3:0] wstrb,
	input  logic       wvalid,
	output logic       wready,
	output logic       bvalid,
	output resp_t      bresp,
	input  logic       bready,
	input  addr_t      araddr,
	input  logic       arvalid,
	output logic       arready,
	output logic       rvalid,
	output data_t      rdata,
	output resp_t      rresp,
	input  logic       rready,
	output logic       xi,
	output logic       nef
);

	logic       ir_load;
	word_t      ir_in;
	word_t      ir;
	pd_ctrl_t   ctrl;
	r0_flags_t  r0;
	pd_decode_t dec;

	pd_regs i_pd_regs (
		.clk_sys, .rst_n,
		.awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
		.bvalid, .bresp, .bready,
		.araddr, .arvalid, .arready, .rvalid, .rdata, .rresp, .rready,
		.ir, .dec, .xi, .nef,
		.ir_load, .ir_in, .ctrl, .r0
	);

	instr_decoder i_instr_decoder (
		.clk_sys, .rst_n, .ir_load, .ir_in,
		.si1 (ctrl.si1),
		.ir, .dec
	);

	legality_check #(
		.INOU_USER_ILLEGAL (INOU_USER_ILLEGAL)
	) i_legality_check (
		.dec, .ctrl, .r0, .xi, .nef
	);

endmodule

// File: tb_pd.sv
// Directed testbench of the decode stage. Drives pd_top over AXI4-Lite,
// predicts STATUS, xi and nef from the decode rules and counts mismatches.
module tb_pd
	import pd_pkg::*;
;
	timeunit 1ns;
	timeprecision 100ps;

	localparam bit INOU_TRAP = 1'b1;	// IN and OU trap in user mode
	localparam logic [31:0] SEED = 32'h5170b2aa;
	// About 1100 transactions of at most 6 cycles with stalls, three times over
	localparam int TIMEOUT_CYCLES = 20000;
	localparam int FZ = 0;	// R0 flag positions
	localparam int FM = 1;
	localparam int FV = 2;
	localparam int FC = 3;
	localparam int FL = 4;
	localparam int FE = 5;
	localparam int FG = 6;
	localparam int FY = 7;
	localparam int FX = 8;

	logic        clk_sys;
	logic        rst_n;
	logic [3:0]  awaddr;
	logic        awvalid;
	logic        awready;
	logic [31:0] wdata;
	logic [3:0]  wstrb;
	logic        wvalid;
	logic        wready;
	logic        bvalid;
	logic [1:0]  bresp;
	logic        bready;
	logic [3:0]  araddr;
	logic        arvalid;
	logic        arready;
	logic        rvalid;
	logic [31:0] rdata;
	logic [1:0]  rresp;
	logic        rready;
	logic        xi;
	logic        nef;

	logic [31:0] lfsr;
	logic        stall_on;	// Random bready and rready stalls
	logic        aw_seen;	// Handshakes of the last rising edge
	logic        w_seen;
	logic        ar_seen;
	int          cycles;
	int          errors;
	int          checks;
	int          tests;
	logic [15:0] m_ir;	// Expected IR, CTRL and R0
	logic [3:0]  m_ctrl;
	logic [8:0]  m_r0;

	pd_top #(.INOU_USER_ILLEGAL (INOU_TRAP)) i_pd_top (.*);

	always #10 clk_sys = ~clk_sys;

	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (cycles == TIMEOUT_CYCLES) begin
			$display("Timeout after %0d cycles, the DUT stopped answering", cycles);
			$display("Errors found");
			$finish;
		end
	end

	// Registered so the falling edge sees what the rising edge accepted
	always @(posedge clk_sys) begin
		aw_seen <= awvalid && awready;
		w_seen  <= wvalid && wready;
		ar_seen <= arvalid && arready;
	end

	// Fibonacci LFSR, taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic draw_bits(input int n, output logic [31:0] v);
		v = '0;
		repeat (n) begin
			lfsr = lfsr_step(lfsr);
			v = {v[30:0], lfsr[0]};	// One step per bit
		end
	endtask

	task automatic check_val(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			$display("Error: %s is %h, expected %h", what, got, exp);
			errors++;
		end
	endtask

	task automatic note_failure(input string msg);
		$display("Failure: %s", msg);
		errors++;
	endtask

	task automatic finish_test(input string name, input int err_start);
		tests++;
		$display("Test %s finished with %0d errors", name, errors - err_start);
	endtask

	function automatic logic [15:0] make_word(input logic [5:0] op, input logic [2:0] a,
		input logic [2:0] b, input logic [2:0] c);
		return {op, 1'b0, a, b, c};	// D bit left clear
	endfunction

	// Expected STATUS for an IR value, CTRL {mc3, p, si1, q} and R0 flags
	function automatic logic [31:0] ref_status(input logic [15:0] w, input logic [3:0] c,
		input logic [8:0] f);
		logic [1:0]  grp;
		logic [3:0]  op;
		logic [2:0]  a;
		logic [2:0]  b;
		logic [2:0]  cf;
		logic        in_ou;
		logic        s_op;
		logic        c_op;
		logic        bn_op;
		logic        taken;
		logic        xi_e;
		logic [31:0] st;
		grp   = w[15:14];	// IR bits 0..1
		op    = w[13:10];
		a     = w[8:6];
		b     = w[5:3];
		cf    = w[2:0];
		in_ou = (grp == 2'b01) && (op == 4'd13 || op == 4'd14);
		s_op  = (grp == 2'b11) && (op == 4'd11);
		c_op  = (grp == 2'b11) && (op == 4'd10);
		bn_op = (grp == 2'b11) && (op == 4'd15);
		xi_e  = (grp == 2'b00);
		if (c[0] && (s_op || (INOU_TRAP && in_ou) || (bn_op && a >= 3'd5)))
			xi_e = 1'b1;	// Privileged in user mode
		if (s_op && a >= 3'd5)
			xi_e = 1'b1;
		if (c_op && (b[2] || (b[1] && b[0])))
			xi_e = 1'b1;
		if (bn_op && a == 3'd5 && c[3])
			xi_e = 1'b1;	// MD past the limit
		if (c_op && b == 3'd1 && (cf[2] || cf[1]))
			xi_e = 1'b1;
		taken = 1'b1;
		if (grp == 2'b11 && op == 4'd12) begin	// J
			case (a)
				3'd1: taken = f[FL];
				3'd2: taken = f[FE];
				3'd3: taken = f[FG];
				3'd4: taken = f[FZ];
				3'd5: taken = f[FM];
				3'd6: taken = !f[FE];	// JN
				default: ;
			endcase
		end else if (grp == 2'b11 && op == 4'd8) begin	// JS
			case (a)
				3'd1: taken = f[FL];
				3'd2: taken = f[FE];
				3'd3: taken = f[FG];
				3'd4: taken = f[FV];
				3'd5: taken = f[FX];
				3'd6: taken = f[FY];
				3'd7: taken = f[FC];
				default: ;
			endcase
		end
		st      = '0;
		st[0]   = xi_e;
		st[1]   = xi_e || c[2] || !taken;
		st[2]   = (cf != 3'd0);
		st[3]   = (b == 3'd0);
		st[4]   = in_ou;
		st[5]   = s_op && (a == 3'd0);	// HLT
		st[6]   = s_op;
		st[9:7] = a;
		return st;
	endfunction

	task automatic stall_cycles(output int n);
		logic [31:0] v;
		n = 0;
		if (stall_on) begin
			draw_bits(2, v);
			n = int'(v[1:0]);	// 0 to 3 cycles
		end
	endtask

	task automatic axi_write(input logic [3:0] addr, input logic [31:0] data,
		output logic [1:0] resp);
		int stall;
		@(negedge clk_sys);
		awaddr  = addr;
		wdata   = data;
		wstrb   = 4'hf;
		awvalid = 1'b1;
		wvalid  = 1'b1;
		@(negedge clk_sys);
		while (!(aw_seen || w_seen)) @(negedge clk_sys);
		awvalid = 1'b0;
		wvalid  = 1'b0;
		check_val("awready", 32'(aw_seen), 32'h1);	// Both channels together
		check_val("wready", 32'(w_seen), 32'h1);
		if (!bvalid)
			note_failure("no write response one cycle after acceptance");
		resp    = bresp;
		stall_cycles(stall);
		repeat (stall) begin
			@(negedge clk_sys);
			if (!bvalid)
				note_failure("write response dropped before bready");
		end
		bready = 1'b1;
		@(negedge clk_sys);
		bready = 1'b0;
		if (bvalid)
			note_failure("write response repeated after bready");
	endtask

	task automatic axi_read(input logic [3:0] addr, output logic [31:0] data,
		output logic [1:0] resp);
		int stall;
		@(negedge clk_sys);
		araddr  = addr;
		arvalid = 1'b1;
		@(negedge clk_sys);
		while (!ar_seen) @(negedge clk_sys);	// arready seen on the rising edge
		arvalid = 1'b0;
		if (!rvalid)
			note_failure("no read data one cycle after acceptance");
		data    = rdata;
		resp    = rresp;
		stall_cycles(stall);
		repeat (stall) begin
			@(negedge clk_sys);
			if (!rvalid)
				note_failure("read response dropped before rready");
		end
		if (rdata !== data)
			note_failure("read data changed while waiting for rready");
		rready = 1'b1;
		@(negedge clk_sys);
		rready = 1'b0;
		if (rvalid)
			note_failure("read response repeated after rready");
	endtask

	task automatic write_reg(input logic [3:0] addr, input logic [31:0] data);
		logic [1:0] resp;
		axi_write(addr, data, resp);
		check_val("bresp", 32'(resp), 32'(RESP_OKAY));
	endtask

	task automatic read_reg(input logic [3:0] addr, output logic [31:0] data);
		logic [1:0] resp;
		axi_read(addr, data, resp);
		check_val("rresp", 32'(resp), 32'(RESP_OKAY));
	endtask

	task automatic set_ctrl(input logic [3:0] c);
		write_reg(REG_CTRL, 32'(c));
		m_ctrl = c;
		if (c[1])
			m_ir[15:14] = 2'b00;	// SI1 clears the group bits
	endtask

	task automatic set_r0(input logic [8:0] f);
		write_reg(REG_R0, 32'(f));
		m_r0 = f;
	endtask

	task automatic load_ir(input logic [15:0] w);
		write_reg(REG_IR, {16'h0, w});
		m_ir = m_ctrl[1] ? {2'b00, w[13:0]} : w;
	endtask

	// Reads IR and STATUS and checks them and the xi and nef ports
	task automatic check_decode(output logic [31:0] st);
		logic [31:0] d;
		logic [31:0] exp;
		exp = ref_status(m_ir, m_ctrl, m_r0);
		read_reg(REG_IR, d);
		check_val("IR", d, {16'h0, m_ir});
		read_reg(REG_STATUS, st);
		check_val("STATUS", st, exp);
		check_val("xi", 32'(xi), 32'(exp[0]));
		check_val("nef", 32'(nef), 32'(exp[1]));
	endtask

	task automatic test_reset();
		int          e0;
		logic [31:0] d;
		logic [1:0]  r;
		e0 = errors;
		check_val("xi", 32'(xi), 32'h1);	// IR zero is group 00
		check_val("nef", 32'(nef), 32'h1);
		check_decode(d);
		set_ctrl(4'b0101);
		read_reg(REG_CTRL, d);
		check_val("CTRL", d, 32'h5);
		set_ctrl(4'b1010);
		read_reg(REG_CTRL, d);
		check_val("CTRL", d, 32'ha);
		set_ctrl(4'b0000);
		set_r0(9'h0a5);
		read_reg(REG_R0, d);
		check_val("R0", d, 32'h0a5);
		axi_write(REG_R0, 32'hffff_ffff, r);	// Upper bits dropped
		check_val("bresp", 32'(r), 32'(RESP_OKAY));
		m_r0 = 9'h1ff;
		read_reg(REG_R0, d);
		check_val("R0", d, 32'h1ff);
		axi_write(REG_STATUS, 32'hffff_ffff, r);
		check_val("bresp", 32'(r), 32'(RESP_SLVERR));
		axi_write(4'h2, 32'h0000_000f, r);
		check_val("bresp", 32'(r), 32'(RESP_SLVERR));
		read_reg(REG_CTRL, d);
		check_val("CTRL", d, 32'(m_ctrl));
		read_reg(REG_R0, d);
		check_val("R0", d, 32'(m_r0));
		check_decode(d);
		axi_read(4'h6, d, r);
		check_val("rdata", d, 32'h0);
		check_val("rresp", 32'(r), 32'(RESP_SLVERR));
		finish_test("reset and register access", e0);
	endtask

	task automatic test_decode();
		int          e0;
		logic [31:0] v;
		logic [31:0] st;
		e0 = errors;
		set_ctrl(4'b0000);
		draw_bits(9, v);
		set_r0(v[8:0]);
		for (int op = 0; op < 64; op++) begin
			draw_bits(10, v);
			load_ir({6'(op), v[9:0]});	// Random low bits
			check_decode(st);
		end
		finish_test("group and field decode", e0);
	endtask

	task automatic test_illegal();
		int          e0;
		logic [15:0] cases[$];
		logic [31:0] st;
		e0 = errors;
		cases.push_back(make_word(6'd5, 3'd1, 3'd0, 3'd0));	// Group 00
		for (int a = 0; a < 8; a++)
			cases.push_back(make_word(6'd59, 3'(a), 3'd0, 3'd0));	// S
		for (int a = 4; a < 8; a++)
			cases.push_back(make_word(6'd63, 3'(a), 3'd0, 3'd0));	// B/N
		cases.push_back(make_word(6'd30, 3'd2, 3'd0, 3'd1));	// IN
		cases.push_back(make_word(6'd29, 3'd2, 3'd0, 3'd1));	// OU
		cases.push_back(make_word(6'd58, 3'd0, 3'd4, 3'd0));	// C forms
		cases.push_back(make_word(6'd58, 3'd0, 3'd3, 3'd0));
		cases.push_back(make_word(6'd58, 3'd0, 3'd1, 3'd4));
		cases.push_back(make_word(6'd58, 3'd0, 3'd1, 3'd2));
		cases.push_back(make_word(6'd58, 3'd0, 3'd1, 3'd1));
		cases.push_back(make_word(6'd58, 3'd0, 3'd0, 3'd7));
		cases.push_back(make_word(6'd58, 3'd0, 3'd2, 3'd6));
		set_r0(9'h1ff);
		for (int m = 0; m < 4; m++) begin
			set_ctrl({m[1], 2'b00, m[0]});	// mc3 and q
			for (int i = 0; i < cases.size(); i++) begin
				load_ir(cases[i]);
				check_decode(st);
			end
		end
		finish_test("illegal instructions", e0);
	endtask

	task automatic test_jumps();
		int          e0;
		logic [31:0] v;
		logic [31:0] st;
		logic [8:0]  flags[4];
		e0 = errors;
		draw_bits(9, v);
		flags = '{9'h000, 9'h1ff, v[8:0], ~v[8:0]};	// Each flag seen both ways
		set_ctrl(4'b0000);
		for (int j = 0; j < 2; j++) begin
			for (int a = 0; a < 8; a++) begin
				load_ir(make_word(j == 0 ? 6'd60 : 6'd56, 3'(a), 3'd0, 3'd1));
				for (int k = 0; k < 4; k++) begin
					set_r0(flags[k]);
					check_decode(st);
				end
			end
		end
		set_ctrl(4'b0100);	// Skip flag
		for (int j = 0; j < 2; j++) begin
			for (int a = 0; a < 8; a++) begin
				load_ir(make_word(j == 0 ? 6'd60 : 6'd56, 3'(a), 3'd0, 3'd1));
				check_decode(st);
				check_val("nef", 32'(nef), 32'h1);
			end
		end
		finish_test("conditional jumps", e0);
	endtask

	task automatic test_invalidate();
		int          e0;
		logic [31:0] v;
		logic [31:0] st;
		e0 = errors;
		set_ctrl(4'b0000);
		set_r0(9'h000);
		load_ir(make_word(6'd60, 3'd0, 3'd0, 3'd0));	// Plain J, legal
		check_decode(st);
		set_ctrl(4'b0010);
		check_decode(st);
		repeat (8) begin
			draw_bits(14, v);
			load_ir({2'b11, v[13:0]});
			check_decode(st);
			check_val("xi", 32'(xi), 32'h1);
		end
		set_ctrl(4'b0000);	// Cleared bits stay cleared
		check_decode(st);
		finish_test("invalidation", e0);
	endtask

	task automatic test_backpressure();
		int          e0;
		logic [31:0] v;
		logic [31:0] st;
		logic [15:0] words[32];
		logic [3:0]  ctrls[32];
		logic [8:0]  flags[32];
		logic [31:0] first[32];
		e0 = errors;
		for (int i = 0; i < 32; i++) begin
			draw_bits(29, v);
			words[i] = v[15:0];
			ctrls[i] = v[19:16] & 4'b1101;	// SI1 left off
			flags[i] = v[28:20];
		end
		for (int pass = 0; pass < 2; pass++) begin
			stall_on = (pass == 1);
			for (int i = 0; i < 32; i++) begin
				set_ctrl(ctrls[i]);
				set_r0(flags[i]);
				load_ir(words[i]);
				check_decode(st);
				if (pass == 0)
					first[i] = st;
				else
					check_val("STATUS with stalls", st, first[i]);
			end
		end
		stall_on = 1'b0;
		finish_test("back-pressure", e0);
	endtask

	initial begin
		clk_sys  = 1'b0;
		rst_n    = 1'b0;
		awaddr   = '0;
		awvalid  = 1'b0;
		wdata    = '0;
		wstrb    = '0;
		wvalid   = 1'b0;
		bready   = 1'b0;
		araddr   = '0;
		arvalid  = 1'b0;
		rready   = 1'b0;
		lfsr     = SEED;
		stall_on = 1'b0;
		cycles   = 0;
		errors   = 0;
		checks   = 0;
		tests    = 0;
		m_ir     = '0;
		m_ctrl   = '0;
		m_r0     = '0;
		repeat (16) @(negedge clk_sys);
		rst_n = 1'b1;
		test_reset();
		test_decode();
		test_illegal();
		test_jumps();
		test_invalidate();
		test_backpressure();
		$display("Tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

// File: verilog.f
pd_pkg.sv
pd_regs.sv
instr_decoder.sv
legality_check.sv
pd_top.sv
tb_pd.sv
